// File: execCore.f
src/rvPkg.sv
src/aluControl.sv
src/immGen.sv
src/regFile.sv
src/alu.sv
src/execCore.sv
tb/execCore_assert.sv
tb/execCoreTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module execCoreTb -f execCore.f -o execCoreSim &&
    ./obj_dir/execCoreSim | tee /dev/stderr | grep -q "Done: no errors" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: src/alu.sv
module alu import rvPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  y
);

    logic [4:0] shamt;

    // shift amount from low bits of b
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            aluAdd:   y = a + b;
            aluSub:   y = a - b;
            aluSll:   y = a << shamt;
            aluSlt:   y = {31'b0, $signed(a) < $signed(b)};
            aluSltu:  y = {31'b0, a < b};
            aluXor:   y = a ^ b;
            aluSrl:   y = a >> shamt;
            aluSra:   y = word_t'($signed(a) >>> shamt);
            aluOr:    y = a | b;
            aluAnd:   y = a & b;
            // LUI path
            aluPassB: y = b;
            default:  y = '0;
        endcase
    end

endmodule

// File: src/aluControl.sv
module aluControl import rvPkg::*; (
    input  instr_t  instr,
    output decode_t dec
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       bit30;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    always_comb begin
        // unsupported opcode unless matched below
        dec.op      = aluAdd;
        dec.fmt     = fmtBad;
        dec.useImm  = 1'b0;
        dec.writeEn = 1'b0;

        case (opcode)
            opR: begin
                dec.fmt     = fmtR;
                dec.writeEn = 1'b1;
                case (funct3)
                    3'b000:  dec.op = bit30 ? aluSub : aluAdd;
                    3'b001:  dec.op = aluSll;
                    3'b010:  dec.op = aluSlt;
                    3'b011:  dec.op = aluSltu;
                    3'b100:  dec.op = aluXor;
                    3'b101:  dec.op = bit30 ? aluSra : aluSrl;
                    3'b110:  dec.op = aluOr;
                    default: dec.op = aluAnd;
                endcase
            end
            opImm: begin
                dec.fmt     = fmtI;
                dec.useImm  = 1'b1;
                dec.writeEn = 1'b1;
                // no subtract form, bit 30 only matters for right shifts
                case (funct3)
                    3'b000:  dec.op = aluAdd;
                    3'b001:  dec.op = aluSll;
                    3'b010:  dec.op = aluSlt;
                    3'b011:  dec.op = aluSltu;
                    3'b100:  dec.op = aluXor;
                    3'b101:  dec.op = bit30 ? aluSra : aluSrl;
                    3'b110:  dec.op = aluOr;
                    default: dec.op = aluAnd;
                endcase
            end
            opLoad: begin
                // effective address only
                dec.op      = aluAdd;
                dec.fmt     = fmtI;
                dec.useImm  = 1'b1;
                dec.writeEn = 1'b1;
            end
            opLui: begin
                dec.op      = aluPassB;
                dec.fmt     = fmtU;
                dec.useImm  = 1'b1;
                dec.writeEn = 1'b1;
            end
            default: begin
                dec.fmt = fmtBad;
            end
        endcase
    end

endmodule

// File: src/execCore.sv
module execCore import rvPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     instrValid,
    input  instr_t   instr,
    output word_t    result,
    output regAddr_t resultRd,
    output logic     resultValid,
    output logic     illegal
);

    decode_t  dec;
    word_t    imm;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    opB;
    word_t    aluY;
    regAddr_t rs1Addr;
    regAddr_t rs2Addr;
    regAddr_t rdAddr;
    logic     wrEn;
    logic     isBad;

    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    aluControl aluControl_i (
        .instr (instr),
        .dec   (dec)
    );

    immGen immGen_i (
        .instr (instr),
        .fmt   (dec.fmt),
        .imm   (imm)
    );

    // write-back lands at the same edge that registers the result
    assign wrEn = instrValid & dec.writeEn;

    regFile regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (wrEn),
        .wrAddr  (rdAddr),
        .wrData  (aluY)
    );

    // operand B mux
    assign opB = dec.useImm ? imm : rs2Data;

    alu alu_i (
        .a  (rs1Data),
        .b  (opB),
        .op (dec.op),
        .y  (aluY)
    );

    assign isBad = (dec.fmt == fmtBad);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result      <= '0;
            resultRd    <= '0;
            resultValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            // status outputs are single-cycle pulses
            resultValid <= instrValid & ~isBad;
            illegal     <= instrValid & isBad;
            if (instrValid) begin
                result   <= aluY;
                resultRd <= rdAddr;
            end
        end
    end

endmodule

// File: src/immGen.sv
module immGen import rvPkg::*; (
    input  instr_t instr,
    input  fmt_t   fmt,
    output word_t  imm
);

    word_t immI;
    word_t immU;

    // I-type, 12-bit signed
    assign immI = {{20{instr[31]}}, instr[31:20]};

    // U-type, upper 20 bits
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        case (fmt)
            fmtI:    imm = immI;
            fmtU:    imm = immU;
            // R-format and bad opcodes carry no immediate
            default: imm = '0;
        endcase
    end

endmodule

// File: src/regFile.sv
module regFile import rvPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    output word_t    rs1Data,
    output word_t    rs2Data,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// File: src/rvPkg.sv
package rvPkg;

    // datapath widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int numRegs  = 2 ** regAddrW;

    typedef logic [xlen-1:0]     word_t;
    typedef logic [regAddrW-1:0] regAddr_t;
    typedef logic [31:0]         instr_t;
    typedef logic [6:0]          opcode_t;

    // supported major opcodes
    localparam opcode_t opR    = 7'b0110011;
    localparam opcode_t opImm  = 7'b0010011;
    localparam opcode_t opLoad = 7'b0000011;
    localparam opcode_t opLui  = 7'b0110111;

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluOp_t;

    // instruction format class, drives immediate and operand routing
    typedef enum logic [1:0] {
        fmtR   = 2'd0,
        fmtI   = 2'd1,
        fmtU   = 2'd2,
        fmtBad = 2'd3
    } fmt_t;

    // decoded control bundle
    typedef struct packed {
        aluOp_t op;
        fmt_t   fmt;
        logic   useImm;
        logic   writeEn;
    } decode_t;

endpackage

// File: tb/execCoreTb.sv
module execCoreTb import rvPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int waitLimit = 10;

    logic     clk = 1'b0;
    logic     arstN;
    logic     instrValid;
    instr_t   instr;
    word_t    result;
    regAddr_t resultRd;
    logic     resultValid;
    logic     illegal;

    // register file as the ISA sees it
    word_t model [32];
    int    testCount = 0;
    int    errCount = 0;

    string      immNames [8] = '{"slti", "sltiu", "xori", "ori", "andi", "slli", "srli", "srai"};
    logic [2:0] immF3 [8] = '{3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    string      rNames [10] = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra", "or",
                                "and"};
    logic [2:0] rF3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       rAlt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    execCore execCore_i (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .result      (result),
        .resultRd    (resultRd),
        .resultValid (resultValid),
        .illegal     (illegal)
    );

    bind execCore execCoreAssert execCoreAssert_i (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .result      (result),
        .resultRd    (resultRd),
        .resultValid (resultValid),
        .illegal     (illegal)
    );

    always #20 clk = ~clk;

    function automatic instr_t rType(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                     logic [2:0] f3, regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic instr_t iType(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                     regAddr_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t uType(logic [19:0] imm, regAddr_t rd);
        return {imm, rd, opLui};
    endfunction

    // expected result from the RV32I rules and write-back into the model
    task automatic predict(input instr_t ins, output word_t expVal, output logic expBad);
        opcode_t opc;
        word_t   a;
        word_t   b;
        word_t   immI;
        opc = ins[6:0];
        a = model[ins[19:15]];
        immI = {{20{ins[31]}}, ins[31:20]};
        b = (opc == opR) ? model[ins[24:20]] : immI;
        expVal = '0;
        expBad = 1'b0;
        case (opc)
            opLui:  expVal = {ins[31:12], 12'b0};
            opLoad: expVal = a + immI;
            opR, opImm: begin
                case (ins[14:12])
                    3'd0:    expVal = (opc == opR && ins[30]) ? a - b : a + b;
                    3'd1:    expVal = a << b[4:0];
                    3'd2:    expVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3:    expVal = (a < b) ? 32'd1 : 32'd0;
                    3'd4:    expVal = a ^ b;
                    3'd5:    expVal = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6:    expVal = a | b;
                    default: expVal = a & b;
                endcase
            end
            default: expBad = 1'b1;
        endcase
        if (!expBad && ins[11:7] != 5'd0) begin
            model[ins[11:7]] = expVal;
        end
    endtask

    task automatic checkResult(input string name, input word_t expVal, input logic expBad);
        int   waited;
        logic ok;
        waited = 0;
        ok = 1'b1;
        testCount++;
        while (!resultValid && !illegal && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!resultValid && !illegal) begin
            $display("%s: no result or illegal pulse within %0d cycles", name, waitLimit);
            ok = 1'b0;
        end else if (expBad) begin
            assert (illegal) else begin
                $display("FAIL %s expected illegal=1 actual illegal=%0b", name, illegal);
                ok = 1'b0;
            end
        end else begin
            assert (resultValid && result == expVal) else begin
                $display("FAIL %s expected %h actual %h", name, expVal, result);
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("pass %s", name);
        end else begin
            errCount++;
        end
    endtask

    task automatic runOne(input string name, input instr_t ins);
        word_t expVal;
        logic  expBad;
        @(negedge clk);
        instrValid = 1'b1;
        instr = ins;
        predict(ins, expVal, expBad);
        @(negedge clk);
        instrValid = 1'b0;
        checkResult(name, expVal, expBad);
    endtask

    // second instruction is strobed while the first one's result is out
    task automatic runPair(input string nameA, input instr_t insA,
                           input string nameB, input instr_t insB);
        word_t expA;
        word_t expB;
        logic  badA;
        logic  badB;
        @(negedge clk);
        instrValid = 1'b1;
        instr = insA;
        predict(insA, expA, badA);
        @(negedge clk);
        instr = insB;
        predict(insB, expB, badB);
        checkResult(nameA, expA, badA);
        @(negedge clk);
        instrValid = 1'b0;
        checkResult(nameB, expB, badB);
    endtask

    task automatic checkIdle();
        logic ok;
        ok = 1'b1;
        testCount++;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!resultValid && !illegal && result == '0) else begin
                $display("FAIL idle after reset expected 0/0/%h actual %0b/%0b/%h",
                         32'h0, resultValid, illegal, result);
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("pass idle after reset");
        end else begin
            errCount++;
        end
    endtask

    initial begin
        instr_t      ins;
        logic [19:0] upper;
        logic [11:0] imm;
        regAddr_t    src;
        regAddr_t    src2;
        regAddr_t    dst;
        void'($urandom(19791));
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkIdle();

        // x1..x7 get random values and x7 is forced negative
        for (int r = 1; r < 8; r++) begin
            upper = 20'($urandom);
            if (r == 7) begin
                upper[19] = 1'b1;
            end
            imm = 12'($urandom);
            runOne($sformatf("lui x%0d", r), uType(upper, regAddr_t'(r)));
            runOne($sformatf("addi x%0d", r),
                   iType(imm, regAddr_t'(r), 3'b000, regAddr_t'(r), opImm));
        end

        // each immediate op on x7 and on a random source
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 2; n++) begin
                src = (n == 0) ? 5'd7 : regAddr_t'(1 + $urandom_range(5));
                imm = 12'($urandom);
                if (k >= 5) begin
                    imm = {(k == 7) ? 7'b0100000 : 7'b0000000, 5'($urandom)};
                end
                runOne($sformatf("%s x%0d, x%0d", immNames[k], 8 + k, src),
                       iType(imm, src, immF3[k], regAddr_t'(8 + k), opImm));
            end
        end

        for (int k = 0; k < 10; k++) begin
            src = regAddr_t'(1 + $urandom_range(6));
            src2 = regAddr_t'(1 + $urandom_range(6));
            dst = regAddr_t'(16 + k);
            runPair($sformatf("%s x%0d", rNames[k], dst),
                    rType({1'b0, rAlt[k], 5'b0}, src2, src, rF3[k], dst),
                    $sformatf("add after %s", rNames[k]),
                    rType(7'b0, src, dst, 3'b000, 5'd26));
        end

        // x0 stays zero
        runOne("addi x0", iType(12'h123, 5'd3, 3'b000, 5'd0, opImm));
        runOne("add x20, x0, x0", rType(7'b0, 5'd0, 5'd0, 3'b000, 5'd20));
        runOne("or x21, x0, x7", rType(7'b0, 5'd7, 5'd0, 3'b110, 5'd21));

        imm = 12'($urandom);
        runOne("lw x22", iType(imm, 5'd3, 3'b010, 5'd22, opLoad));
        ins = $urandom;
        ins[11:7] = 5'd2;
        ins[6:0] = 7'b1100011;
        runOne("branch opcode", ins);
        ins = $urandom;
        ins[11:7] = 5'd2;
        ins[6:0] = 7'b0100011;
        runOne("store opcode", ins);
        runOne("read x2 after illegal", iType(12'h000, 5'd2, 3'b000, 5'd23, opImm));

        $display("tests run: %0d, failed: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb/execCore_assert.sv
module execCoreAssert import rvPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     instrValid,
    input instr_t   instr,
    input word_t    result,
    input regAddr_t resultRd,
    input logic     resultValid,
    input logic     illegal
);

    timeunit 1ns;
    timeprecision 100ps;

    // every strobe gives exactly one pulse on the next cycle
    strobeGivesPulse: assert property (@(posedge clk) disable iff (!arstN)
        instrValid |=> (resultValid ^ illegal))
        else $error("strobe not followed by exactly one result pulse");

    // no pulse without a strobe one cycle earlier
    pulseNeedsStrobe: assert property (@(posedge clk) disable iff (!arstN)
        (resultValid || illegal) |-> $past(instrValid))
        else $error("result pulse without a strobe one cycle earlier");

    pulsesExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(resultValid && illegal))
        else $error("resultValid and illegal high together");

    // outputs come out of reset cleared
    clearAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> (result == '0 && !resultValid && !illegal))
        else $error("outputs not cleared after reset");

    rdFollowsInstr: assert property (@(posedge clk) disable iff (!arstN)
        instrValid |=> (resultRd == $past(instr[11:7])))
        else $error("resultRd does not match rd of the strobed instruction");

endmodule
